/* compile.f */
+incdir+hdl
hdl/int_pkg.sv
hdl/issue_queue.sv
hdl/int_regfile.sv
hdl/operand_read.sv
hdl/int_alu.sv
hdl/int_block.sv
testbench/tb_int_block.sv

/* hdl/int_alu.sv */
`timescale 1ns/1ps

module int_alu import int_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_stall,
    input  logic      i_exe_vld,
    input  alu_op_t   i_exe_op,
    input  xdata_t    i_src1,
    input  xdata_t    i_src2,
    input  preg_idx_t i_exe_rd,
    output logic      o_wb_vld,
    output wb_t       o_wb
);
    xdata_t     result;
    logic [4:0] shamt;

    assign shamt = i_src2[4:0];

    always_comb begin
        case (i_exe_op)
            ALU_ADD: result = i_src1 + i_src2;
            ALU_SUB: result = i_src1 - i_src2;
            ALU_AND: result = i_src1 & i_src2;
            ALU_OR:  result = i_src1 | i_src2;
            ALU_XOR: result = i_src1 ^ i_src2;
            ALU_SLL: result = i_src1 << shamt;
            ALU_SRL: result = i_src1 >> shamt;
            ALU_SLT: result = xdata_t'($signed(i_src1) < $signed(i_src2));
            default: result = '0;
        endcase
    end

    // output register holds while writeback is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_vld <= 1'b0;
        end else if (!i_stall) begin
            o_wb_vld <= i_exe_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall && i_exe_vld) begin
            o_wb.rd <= i_exe_rd;
            o_wb.data <= result;
        end
    end

endmodule

/* hdl/int_block.sv */
`timescale 1ns/1ps

module int_block import int_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_disp_vld,
    input  uop_t i_disp_uop,
    input  logic i_disp_rdy1,
    input  logic i_disp_rdy2,
    output logic o_disp_ready,
    input  logic i_ext_wb_vld,
    input  wb_t  i_ext_wb,
    input  logic i_wb_stall,
    output logic o_wb_vld,
    output wb_t  o_wb
);
    wake_t     ext_wake;
    logic      sel_vld;
    uop_t      sel_uop;
    preg_idx_t raddr1;
    preg_idx_t raddr2;
    xdata_t    rdata1;
    xdata_t    rdata2;
    logic      exe_vld;
    alu_op_t   exe_op;
    xdata_t    src1;
    xdata_t    src2;
    preg_idx_t exe_rd;
    logic      alu_we;

    assign ext_wake = '{vld: i_ext_wb_vld, rd: i_ext_wb.rd};
    // a result retires on the edge it is delivered
    assign alu_we = o_wb_vld && !i_wb_stall;

    // own alu wakeup is consumed inside the queue
    issue_queue u_issue_queue (
        .clk          (clk),
        .rst          (rst),
        .i_stall      (i_wb_stall),
        .i_disp_vld   (i_disp_vld),
        .i_disp_uop   (i_disp_uop),
        .i_disp_rdy1  (i_disp_rdy1),
        .i_disp_rdy2  (i_disp_rdy2),
        .i_ext_wake   (ext_wake),
        .o_disp_ready (o_disp_ready),
        .o_sel_vld    (sel_vld),
        .o_sel_uop    (sel_uop),
        .o_alu_wake   ()
    );

    int_regfile u_int_regfile (
        .clk      (clk),
        .rst      (rst),
        .i_raddr1 (raddr1),
        .i_raddr2 (raddr2),
        .i_alu_we (alu_we),
        .i_alu_wb (o_wb),
        .i_ext_we (i_ext_wb_vld),
        .i_ext_wb (i_ext_wb),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    operand_read u_operand_read (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (i_wb_stall),
        .i_sel_vld     (sel_vld),
        .i_sel_uop     (sel_uop),
        .i_rf_data1    (rdata1),
        .i_rf_data2    (rdata2),
        .i_alu_fwd_vld (o_wb_vld),
        .i_alu_fwd     (o_wb),
        .i_ext_vld     (i_ext_wb_vld),
        .i_ext         (i_ext_wb),
        .o_raddr1      (raddr1),
        .o_raddr2      (raddr2),
        .o_exe_vld     (exe_vld),
        .o_exe_op      (exe_op),
        .o_src1        (src1),
        .o_src2        (src2),
        .o_exe_rd      (exe_rd)
    );

    int_alu u_int_alu (
        .clk       (clk),
        .rst       (rst),
        .i_stall   (i_wb_stall),
        .i_exe_vld (exe_vld),
        .i_exe_op  (exe_op),
        .i_src1    (src1),
        .i_src2    (src2),
        .i_exe_rd  (exe_rd),
        .o_wb_vld  (o_wb_vld),
        .o_wb      (o_wb)
    );

endmodule

/* hdl/int_config.svh */
`ifndef INT_CONFIG_SVH
`define INT_CONFIG_SVH

// data path width in bits
`define INT_XLEN 32

// physical register count must be a power of two
`define INT_PREG_NUM 32

// issue queue entries
`define INT_IQ_DEPTH 8

// immediate bits kept per entry and sign-extended at operand read
`define INT_IMM_WIDTH 12

`endif

/* hdl/int_pkg.sv */
`include "int_config.svh"

package int_pkg;

    // physical register tag
    typedef logic [$clog2(`INT_PREG_NUM)-1:0] preg_idx_t;

    // one data word
    typedef logic [`INT_XLEN-1:0] xdata_t;

    // alu operations where slt compares signed
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // renamed micro-op as it sits in the queue
    typedef struct packed {
        alu_op_t                   op;
        preg_idx_t                 rs1;
        preg_idx_t                 rs2;
        logic                      use_imm;
        logic [`INT_IMM_WIDTH-1:0] imm;
        preg_idx_t                 rd;
    } uop_t;

    // result headed for the register file
    typedef struct packed {
        preg_idx_t rd;
        xdata_t    data;
    } wb_t;

    // tag broadcast to waiting entries
    typedef struct packed {
        logic      vld;
        preg_idx_t rd;
    } wake_t;

endpackage

/* hdl/int_regfile.sv */
`timescale 1ns/1ps
`include "int_config.svh"

module int_regfile import int_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  preg_idx_t i_raddr1,
    input  preg_idx_t i_raddr2,
    input  logic      i_alu_we,
    input  wb_t       i_alu_wb,
    input  logic      i_ext_we,
    input  wb_t       i_ext_wb,
    output xdata_t    o_rdata1,
    output xdata_t    o_rdata2
);
    xdata_t regs [`INT_PREG_NUM];

    // renaming keeps the two write tags apart
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `INT_PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_alu_we) begin
                regs[i_alu_wb.rd] <= i_alu_wb.data;
            end
            if (i_ext_we) begin
                regs[i_ext_wb.rd] <= i_ext_wb.data;
            end
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

/* hdl/issue_queue.sv */
`timescale 1ns/1ps
`include "int_config.svh"

module issue_queue import int_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_stall,
    input  logic  i_disp_vld,
    input  uop_t  i_disp_uop,
    input  logic  i_disp_rdy1,
    input  logic  i_disp_rdy2,
    input  wake_t i_ext_wake,
    output logic  o_disp_ready,
    output logic  o_sel_vld,
    output uop_t  o_sel_uop,
    output wake_t o_alu_wake
);
    localparam int DEPTH = `INT_IQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] ent_vld;
    logic [DEPTH-1:0] ent_rdy1;
    logic [DEPTH-1:0] ent_rdy2;
    uop_t             ent_uop [DEPTH];
    // number of younger entries still in the queue
    logic [IDX_W-1:0] ent_age [DEPTH];

    logic             run_q;
    logic             full;
    logic             disp_fire;
    logic             sel_found;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic [IDX_W-1:0] sel_age;

    function automatic logic wake_hit(wake_t w_a, wake_t w_b, preg_idx_t tag);
        return (w_a.vld && (w_a.rd == tag)) || (w_b.vld && (w_b.rd == tag));
    endfunction

    always_comb begin
        full = &ent_vld;
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld[i]) begin
                free_idx = IDX_W'(i);
            end
        end
        // oldest ready entry has the largest age
        sel_found = 1'b0;
        sel_idx = '0;
        sel_age = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_vld[i] && ent_rdy1[i] && ent_rdy2[i]) begin
                if (!sel_found || (ent_age[i] > sel_age)) begin
                    sel_found = 1'b1;
                    sel_idx = IDX_W'(i);
                    sel_age = ent_age[i];
                end
            end
        end
    end

    assign o_disp_ready = run_q && !full && !i_stall;
    assign disp_fire    = i_disp_vld && o_disp_ready;
    assign o_sel_vld    = sel_found && !i_stall;
    assign o_sel_uop    = ent_uop[sel_idx];
    // selected rd wakes its dependents for selection next cycle
    assign o_alu_wake   = '{vld: o_sel_vld, rd: o_sel_uop.rd};

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            ent_vld <= '0;
            ent_rdy1 <= '0;
            ent_rdy2 <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                ent_age[i] <= '0;
            end
        end else begin
            run_q <= 1'b1;
            for (int i = 0; i < DEPTH; i++) begin
                if (ent_vld[i]) begin
                    ent_rdy1[i] <= ent_rdy1[i] | wake_hit(i_ext_wake, o_alu_wake, ent_uop[i].rs1);
                    ent_rdy2[i] <= ent_rdy2[i] | wake_hit(i_ext_wake, o_alu_wake, ent_uop[i].rs2);
                    // older than the issued entry loses one younger neighbour
                    ent_age[i] <= ent_age[i] + IDX_W'(disp_fire)
                                  - IDX_W'(o_sel_vld && (ent_age[i] > sel_age));
                end
            end
            if (o_sel_vld) begin
                ent_vld[sel_idx] <= 1'b0;
            end
            if (disp_fire) begin
                ent_vld[free_idx] <= 1'b1;
                ent_age[free_idx] <= '0;
                ent_rdy1[free_idx] <= i_disp_rdy1
                                      | wake_hit(i_ext_wake, o_alu_wake, i_disp_uop.rs1);
                ent_rdy2[free_idx] <= i_disp_rdy2 | i_disp_uop.use_imm
                                      | wake_hit(i_ext_wake, o_alu_wake, i_disp_uop.rs2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            ent_uop[free_idx] <= i_disp_uop;
        end
    end

endmodule

/* hdl/operand_read.sv */
`timescale 1ns/1ps
`include "int_config.svh"

module operand_read import int_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_stall,
    input  logic      i_sel_vld,
    input  uop_t      i_sel_uop,
    input  xdata_t    i_rf_data1,
    input  xdata_t    i_rf_data2,
    input  logic      i_alu_fwd_vld,
    input  wb_t       i_alu_fwd,
    input  logic      i_ext_vld,
    input  wb_t       i_ext,
    output preg_idx_t o_raddr1,
    output preg_idx_t o_raddr2,
    output logic      o_exe_vld,
    output alu_op_t   o_exe_op,
    output xdata_t    o_src1,
    output xdata_t    o_src2,
    output preg_idx_t o_exe_rd
);
    logic   exe_vld_q;
    uop_t   uop_q;
    xdata_t imm_ext;

    // alu output first, then same-cycle external writeback, then the file
    function automatic xdata_t resolve(preg_idx_t tag, xdata_t rf_data, logic alu_vld,
                                       wb_t alu_wb, logic ext_vld, wb_t ext_wb);
        if (alu_vld && (alu_wb.rd == tag)) begin
            return alu_wb.data;
        end
        if (ext_vld && (ext_wb.rd == tag)) begin
            return ext_wb.data;
        end
        return rf_data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_vld_q <= 1'b0;
        end else if (!i_stall) begin
            exe_vld_q <= i_sel_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall && i_sel_vld) begin
            uop_q <= i_sel_uop;
        end
    end

    assign o_raddr1 = uop_q.rs1;
    assign o_raddr2 = uop_q.rs2;

    assign imm_ext = {{(`INT_XLEN - `INT_IMM_WIDTH){uop_q.imm[`INT_IMM_WIDTH-1]}}, uop_q.imm};

    assign o_src1 = resolve(uop_q.rs1, i_rf_data1, i_alu_fwd_vld, i_alu_fwd, i_ext_vld, i_ext);
    assign o_src2 = uop_q.use_imm ? imm_ext
                  : resolve(uop_q.rs2, i_rf_data2, i_alu_fwd_vld, i_alu_fwd, i_ext_vld, i_ext);

    assign o_exe_vld = exe_vld_q;
    assign o_exe_op  = uop_q.op;
    assign o_exe_rd  = uop_q.rd;

endmodule

/* run.sh */
#!/bin/sh
# build and run the int_block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_int_block -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_int_block)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation did not run to completion"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* testbench/int_block_input.txt */
# P tag value | D op rs1 rs2 use_imm imm rd rdy1 rdy2 expected | L tag value | S start length
# op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt; values and imm in hex
P 1 00000005
P 2 0000000c
P 3 fffffff0
P 4 12345678
P 5 00000003
D 0 1 2 0 000 8 1 1 00000011
D 1 1 2 0 000 9 1 1 fffffff9
D 2 4 3 0 000 10 1 1 12345670
D 3 1 2 0 000 11 1 1 0000000d
D 4 4 0 1 fff 12 1 1 edcba987
D 5 1 0 1 004 13 1 1 00000050
D 6 3 5 0 000 14 1 1 1ffffffe
D 7 3 1 0 000 15 1 1 00000001
D 0 8 5 0 000 16 1 1 00000014
D 0 16 16 0 000 17 1 1 00000028
D 1 17 1 0 000 18 1 1 00000023
D 0 6 1 0 000 19 0 1 000001f5
D 2 19 0 1 0ff 20 0 1 000000f5
D 5 20 5 0 000 21 0 1 000007a8
D 0 1 2 0 000 22 1 1 00000011
L 6 000001f0
D 4 2 7 0 000 23 1 0 0000fff3
L 7 0000ffff
S 2 8
D 0 1 0 1 001 24 1 1 00000006
D 0 24 0 1 001 25 1 1 00000007
D 0 25 0 1 001 26 1 1 00000008
D 0 2 0 1 800 27 1 1 fffff80c
D 7 1 3 0 000 28 1 1 00000000
D 1 3 1 0 000 29 1 1 ffffffeb
D 6 4 0 1 004 30 1 1 01234567
D 5 2 0 1 01c 31 1 1 c0000000
D 3 3 5 0 000 0 1 1 fffffff3

/* testbench/tb_int_block.sv */
`timescale 1ns/1ps
`include "int_config.svh"

module tb_int_block import int_pkg::*; ();
    logic  clk;
    logic  rst;
    logic  i_disp_vld;
    uop_t  i_disp_uop;
    logic  i_disp_rdy1;
    logic  i_disp_rdy2;
    logic  o_disp_ready;
    logic  i_ext_wb_vld;
    wb_t   i_ext_wb;
    logic  i_wb_stall;
    logic  o_wb_vld;
    wb_t   o_wb;

    string  lines[$];
    xdata_t exp_val [`INT_PREG_NUM];
    logic   exp_pending [`INT_PREG_NUM];
    int     cycle = 0;
    int     limit = 0;
    int     stall_begin = 0;
    int     stall_end = 0;
    int     n_disp = 0;
    int     received = 0;
    int     value_errs = 0;
    int     flag_errs = 0;
    int     count_errs = 0;
    logic   hold_chk = 1'b0;
    wb_t    held_wb;

    int_block u_dut (
        .clk          (clk),
        .rst          (rst),
        .i_disp_vld   (i_disp_vld),
        .i_disp_uop   (i_disp_uop),
        .i_disp_rdy1  (i_disp_rdy1),
        .i_disp_rdy2  (i_disp_rdy2),
        .o_disp_ready (o_disp_ready),
        .i_ext_wb_vld (i_ext_wb_vld),
        .i_ext_wb     (i_ext_wb),
        .i_wb_stall   (i_wb_stall),
        .o_wb_vld     (o_wb_vld),
        .o_wb         (o_wb)
    );

    always #10 clk = ~clk;

    task automatic check_wb(input wb_t actual, input wb_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR %0t: %s tag %0d expected %h got %h", $time, what,
                     expected.rd, expected.data, actual.data);
            value_errs++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERROR %0t: %s expected %b got %b", $time, what, expected, actual);
            flag_errs++;
        end
    endtask

    task automatic check_count(input int actual);
        if (actual != n_disp) begin
            $display("ERROR %0t: %0d writebacks for %0d dispatched ops", $time, actual, n_disp);
            count_errs++;
        end
    endtask

    // drive one external writeback for a single cycle
    task automatic ext_write(input int tag, input xdata_t val);
        i_ext_wb_vld = 1'b1;
        i_ext_wb = '{rd: preg_idx_t'(tag), data: val};
        @(posedge clk);
        #2;
        i_ext_wb_vld = 1'b0;
    endtask

    task automatic dispatch(input uop_t uop, input logic rdy1, input logic rdy2);
        logic taken;
        i_disp_vld = 1'b1;
        i_disp_uop = uop;
        i_disp_rdy1 = rdy1;
        i_disp_rdy2 = rdy2;
        do begin
            @(posedge clk);
            taken = o_disp_ready;
        end while (!taken);
        #2;
        i_disp_vld = 1'b0;
    endtask

    // stall window follows the cycle counter
    always @(posedge clk) begin
        #2;
        i_wb_stall = (cycle >= stall_begin) && (cycle < stall_end);
    end

    // output monitor samples at the edge before the DUT updates
    always @(posedge clk) begin
        cycle++;
        if (limit > 0 && cycle > limit) begin
            $display("run hung: only %0d of %0d writebacks after %0d cycles",
                     received, n_disp, cycle);
            $display("Testbench failed");
            $finish;
        end else if (!rst) begin
            if (hold_chk) begin
                check_flag(o_wb_vld, 1'b1, "o_wb_vld held in stall");
                check_wb(o_wb, held_wb, "o_wb held in stall");
            end
            hold_chk = i_wb_stall && o_wb_vld;
            held_wb = o_wb;
            if (i_wb_stall) begin
                check_flag(o_disp_ready, 1'b0, "o_disp_ready in stall");
            end
            if (o_wb_vld && !i_wb_stall) begin
                received++;
                if (!exp_pending[o_wb.rd]) begin
                    $display("unexpected or repeated writeback for tag %0d at %0t",
                             o_wb.rd, $time);
                    count_errs++;
                end else begin
                    check_wb(o_wb, '{rd: o_wb.rd, data: exp_val[o_wb.rd]}, "writeback");
                    exp_pending[o_wb.rd] = 1'b0;
                end
            end
        end
    end

    initial begin
        int     fd;
        int     gap;
        int     f_op, f_rs1, f_rs2, f_ui, f_rd, f_r1, f_r2, f_a, f_b;
        xdata_t f_imm;
        xdata_t f_val;
        string  line;
        string  kind;
        uop_t   uop;

        clk = 1'b0;
        rst = 1'b1;
        i_disp_vld = 1'b0;
        i_disp_uop = '0;
        i_disp_rdy1 = 1'b0;
        i_disp_rdy2 = 1'b0;
        i_ext_wb_vld = 1'b0;
        i_ext_wb = '0;
        i_wb_stall = 1'b0;
        void'($urandom(32'hb41b_f9a6));
        for (int i = 0; i < `INT_PREG_NUM; i++) begin
            exp_pending[i] = 1'b0;
        end

        fd = $fopen("testbench/int_block_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("Testbench failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            limit = 40 * lines.size() + 20;

            repeat (10) @(posedge clk);
            #2;
            rst = 1'b0;
            @(posedge clk);
            #2;
            check_flag(o_wb_vld, 1'b0, "o_wb_vld after reset");
            check_flag(o_disp_ready, 1'b1, "o_disp_ready after reset");

            foreach (lines[n]) begin
                kind = lines[n].substr(0, 0);
                if (kind == "P" || kind == "L") begin
                    void'($sscanf(lines[n], "%s %d %h", kind, f_rd, f_val));
                    ext_write(f_rd, f_val);
                end else if (kind == "S") begin
                    void'($sscanf(lines[n], "%s %d %d", kind, f_a, f_b));
                    stall_begin = cycle + f_a;
                    stall_end = stall_begin + f_b;
                end else if (kind == "D") begin
                    void'($sscanf(lines[n], "%s %d %d %d %d %h %d %d %d %h", kind, f_op,
                                  f_rs1, f_rs2, f_ui, f_imm, f_rd, f_r1, f_r2, f_val));
                    uop.op = alu_op_t'(f_op[2:0]);
                    uop.rs1 = preg_idx_t'(f_rs1);
                    uop.rs2 = preg_idx_t'(f_rs2);
                    uop.use_imm = f_ui[0];
                    uop.imm = f_imm[`INT_IMM_WIDTH-1:0];
                    uop.rd = preg_idx_t'(f_rd);
                    exp_val[uop.rd] = f_val;
                    exp_pending[uop.rd] = 1'b1;
                    n_disp++;
                    gap = int'($urandom % 3);
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                    dispatch(uop, f_r1[0], f_r2[0]);
                end
            end

            while (received < n_disp) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            check_count(received);
            $display("errors: value %0d, flag %0d, count %0d", value_errs, flag_errs,
                     count_errs);
            if (value_errs + flag_errs + count_errs == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule
